//--- src.f
+incdir+common
common/pid_pkg.sv
hw/cfg_decode.sv
pid/pid_execute.sv
hw/output_router.sv
hw/pid_core_top.sv
test/tb_pid_core.sv

//--- Bender.yml
package:
  name: pid_core

sources:
  - include_dirs:
      - common
    files:
      - common/pid_pkg.sv
      - hw/cfg_decode.sv
      - pid/pid_execute.sv
      - hw/output_router.sv
      - hw/pid_core_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/tb_pid_core.sv

//--- test/tb_pid_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "pid_defs.svh"

module tb_pid_core import pid_pkg::*; ();

    localparam logic [1:0] KIND_IDLE = 2'd0;
    localparam logic [1:0] KIND_WRITE = 2'd1;
    localparam logic [1:0] KIND_SAMPLE = 2'd2;
    localparam int N_RANDOM = 40;

    // One table row per cycle
    typedef struct packed {
        logic [1:0] kind;
        chan_t chan;
        cfg_addr_t addr;
        logic [15:0] data;
        logic [15:0] exp;
        logic to_dds;
    } step_t;

    typedef struct packed {
        logic [31:0] due;
        chan_t chan;
        logic to_dds;
        logic [15:0] data;
    } expect_t;

    logic wr_en;
    logic reset;
    cfg_write_t cfg;
    sample_in_t sample;
    logic dac_dv;
    logic dac_chan;
    sample_t dac_data;
    logic [`N_DDS-1:0] dds_dv;
    sample_t dds_data;

    step_t table_q[$];
    expect_t exp_q[$];
    int step_cycle;
    int clk_count;
    int cycle_limit;
    logic [31:0] lcg_state;
    chan_t last_chan;

    // Reference model state
    logic signed [15:0] m_set [`N_PID_CHAN];
    logic signed [15:0] m_kp [`N_PID_CHAN];
    logic signed [15:0] m_ki [`N_PID_CHAN];
    logic signed [15:0] m_kd [`N_PID_CHAN];
    logic signed [31:0] m_integ [`N_PID_CHAN];
    logic signed [31:0] m_prev [`N_PID_CHAN];
    logic clr_pending;
    chan_t clr_ch;

    pid_core_top u_dut (
        .wr_en    (wr_en),
        .reset    (reset),
        .cfg      (cfg),
        .sample   (sample),
        .dac_dv   (dac_dv),
        .dac_chan (dac_chan),
        .dac_data (dac_data),
        .dds_dv   (dds_dv),
        .dds_data (dds_data)
    );

    always #4 wr_en = ~wr_en;

    always @(posedge wr_en) begin
        clk_count++;
        if (clk_count > cycle_limit) begin
            fail_run("Timeout: the run took more cycles than the tests need");
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
        $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
        fail_run("Output mismatch");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // ------------------------------
    // PID reference model
    // ------------------------------
    function automatic logic signed [15:0] pid_model(input chan_t ch,
                                                     input logic signed [15:0] x);
        logic signed [31:0] e;
        logic signed [31:0] d;
        logic signed [31:0] s;
        e = m_set[ch] - x;
        m_integ[ch] = m_integ[ch] + e;
        d = e - m_prev[ch];
        m_prev[ch] = e;
        s = m_kp[ch] * e + m_ki[ch] * m_integ[ch] + m_kd[ch] * d;
        s = s >>> `PID_SHIFT;
        if (s > 32767) begin
            return 16'sh7fff;
        end else if (s < -32768) begin
            return 16'sh8000;
        end
        return s[15:0];
    endfunction

    task automatic add_write(input chan_t ch, input cfg_addr_t addr, input logic [15:0] data);
        table_q.push_back('{kind: KIND_WRITE, chan: ch, addr: addr, data: data, exp: 16'h0,
                            to_dds: 1'b0});
    endtask

    task automatic add_sample(input chan_t ch, input logic signed [15:0] data,
                              input logic signed [15:0] exp, input logic to_dds);
        table_q.push_back('{kind: KIND_SAMPLE, chan: ch, addr: 3'd0, data: data, exp: exp,
                            to_dds: to_dds});
    endtask

    task automatic add_idle();
        table_q.push_back('{kind: KIND_IDLE, chan: '0, addr: '0, data: '0, exp: '0,
                            to_dds: 1'b0});
    endtask

    // Drive one cycle and keep the model in step with it
    task automatic apply_step(input step_t s, input logic use_model);
        logic signed [15:0] m;
        // Clear pulse reaches execute one cycle after the write
        if (clr_pending) begin
            m_integ[clr_ch] = '0;
            m_prev[clr_ch] = '0;
            clr_pending = 1'b0;
        end
        cfg = '0;
        sample = '0;
        if (s.kind == KIND_WRITE) begin
            cfg = '{wr: 1'b1, addr: s.addr, chan: s.chan, data: s.data};
            case (s.addr)
                `ADDR_SETPOINT: m_set[s.chan] = s.data;
                `ADDR_KP: m_kp[s.chan] = s.data;
                `ADDR_KI: m_ki[s.chan] = s.data;
                `ADDR_KD: m_kd[s.chan] = s.data;
                `ADDR_CLEAR: begin
                    clr_pending = 1'b1;
                    clr_ch = s.chan;
                end
                default: ;
            endcase
        end else if (s.kind == KIND_SAMPLE) begin
            sample = '{valid: 1'b1, chan: s.chan, data: s.data};
            m = pid_model(s.chan, s.data);
            exp_q.push_back('{due: step_cycle + 4, chan: s.chan,
                              to_dds: use_model ? (s.chan >= `N_DAC) : s.to_dds,
                              data: use_model ? m : s.exp});
        end
    endtask

    function automatic step_t random_step();
        step_t s;
        logic [31:0] r;
        r = lcg_next();
        s = '0;
        // Repeat the previous channel now and then
        s.chan = r[20] ? last_chan : chan_t'(r[17:16]);
        if (r[26:24] == 3'd0) begin
            s.kind = KIND_WRITE;
            s.addr = r[30:28];
            s.data = {{6{r[9]}}, r[9:0]};
        end else begin
            s.kind = KIND_SAMPLE;
            s.data = {{3{r[12]}}, r[12:0]};
        end
        return s;
    endfunction

    // ------------------------------
    // Output checks, every cycle
    // ------------------------------
    task automatic check_outputs();
        expect_t e;
        logic [`N_DDS-1:0] dds_exp;
        logic [15:0] dac_exp;
        if (exp_q.size() > 0 && exp_q[0].due == step_cycle) begin
            e = exp_q.pop_front();
            dds_exp = '0;
            if (e.to_dds) begin
                dds_exp[e.chan - `N_DAC] = 1'b1;
            end
            assert (dac_dv === !e.to_dds)
                else show_mismatch("dac_dv", 16'(!e.to_dds), 16'(dac_dv));
            assert (dds_dv === dds_exp)
                else show_mismatch("dds_dv", 16'(dds_exp), 16'(dds_dv));
            if (e.to_dds) begin
                assert (dds_data === e.data) else show_mismatch("dds_data", e.data, dds_data);
            end else begin
                assert (dac_chan === e.chan[0])
                    else show_mismatch("dac_chan", 16'(e.chan[0]), 16'(dac_chan));
                // Offset binary adds half scale
                dac_exp = e.data + 16'h8000;
                assert (dac_data === dac_exp)
                    else show_mismatch("dac_data", dac_exp, dac_data);
            end
        end else begin
            assert (dac_dv === 1'b0) else show_mismatch("dac_dv", 16'h0, 16'(dac_dv));
            assert (dds_dv === '0) else show_mismatch("dds_dv", 16'h0, 16'(dds_dv));
        end
    endtask

    task automatic build_table();
        repeat (3) add_idle();
        // P only on channel 0
        add_write(2'd0, `ADDR_SETPOINT, 16'd1000);
        add_write(2'd0, `ADDR_KP, 16'd256);
        add_sample(2'd0, 900, 100, 1'b0);
        add_sample(2'd0, 1200, -200, 1'b0);
        add_sample(2'd0, 1000, 0, 1'b0);
        // I with clear on channel 1
        add_write(2'd1, `ADDR_KI, 16'd256);
        add_sample(2'd1, -10, 10, 1'b0);
        add_sample(2'd1, -10, 20, 1'b0);
        add_sample(2'd1, -5, 25, 1'b0);
        add_write(2'd1, `ADDR_CLEAR, 16'd0);
        add_sample(2'd1, -10, 10, 1'b0);
        add_sample(2'd1, -10, 20, 1'b0);
        // D step and saturation on DDS 0
        add_write(2'd2, `ADDR_KD, 16'd2000);
        add_write(2'd2, `ADDR_KP, 16'd256);
        add_sample(2'd2, -5000, 32767, 1'b1);
        add_sample(2'd2, -5000, 5000, 1'b1);
        add_sample(2'd2, 20000, -32768, 1'b1);
        // DDS 1, shift rounds toward minus infinity
        add_write(2'd3, `ADDR_SETPOINT, 16'd100);
        add_write(2'd3, `ADDR_KP, 16'd300);
        add_sample(2'd3, 40, 70, 1'b1);
        add_sample(2'd3, 101, -2, 1'b1);
        repeat (2) add_idle();
    endtask

    task automatic next_cycle();
        @(posedge wr_en);
        #1;
        step_cycle++;
        check_outputs();
    endtask

    initial begin
        step_t s;
        wr_en = 1'b0;
        reset = 1'b1;
        cfg = '0;
        sample = '0;
        step_cycle = 0;
        clk_count = 0;
        lcg_state = 32'd67424;
        last_chan = '0;
        clr_pending = 1'b0;
        clr_ch = '0;
        for (int c = 0; c < `N_PID_CHAN; c++) begin
            m_set[c] = '0;
            m_kp[c] = '0;
            m_ki[c] = '0;
            m_kd[c] = '0;
            m_integ[c] = '0;
            m_prev[c] = '0;
        end
        build_table();
        cycle_limit = table_q.size() + N_RANDOM + 20;

        repeat (4) @(posedge wr_en);
        #1;
        reset = 1'b0;

        foreach (table_q[i]) begin
            next_cycle();
            apply_step(table_q[i], 1'b0);
        end

        // Random phase on mixed channels
        for (int i = 0; i < N_RANDOM; i++) begin
            next_cycle();
            s = random_step();
            last_chan = s.chan;
            apply_step(s, 1'b1);
        end

        // Drain the pipeline
        repeat (6) begin
            next_cycle();
            apply_step('0, 1'b1);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/pid_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pid_defs.svh"

module pid_core_top import pid_pkg::*; (
    input  wire logic           wr_en,
    input  wire logic           reset,
    input  wire cfg_write_t     cfg,
    input  wire sample_in_t     sample,
    output logic                dac_dv,
    output logic                dac_chan,
    output sample_t             dac_data,
    output logic [`N_DDS-1:0]   dds_dv,
    output sample_t             dds_data
);

    pid_gains_t [`N_PID_CHAN-1:0] gains;
    logic clear;
    chan_t clear_chan;
    pid_result_t result;

    // ------------------------------
    // Decode, execute, result
    // ------------------------------
    cfg_decode u_decode (
        .wr_en      (wr_en),
        .reset      (reset),
        .cfg        (cfg),
        .gains      (gains),
        .clear      (clear),
        .clear_chan (clear_chan)
    );

    pid_execute u_execute (
        .wr_en      (wr_en),
        .reset      (reset),
        .sample     (sample),
        .gains      (gains),
        .clear      (clear),
        .clear_chan (clear_chan),
        .result     (result)
    );

    output_router u_result (
        .wr_en      (wr_en),
        .reset      (reset),
        .result     (result),
        .dac_dv     (dac_dv),
        .dac_chan   (dac_chan),
        .dac_data   (dac_data),
        .dds_dv     (dds_dv),
        .dds_data   (dds_data)
    );

endmodule

`default_nettype wire

//--- hw/output_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "pid_defs.svh"

module output_router import pid_pkg::*; (
    input  wire logic           wr_en,
    input  wire logic           reset,
    input  wire pid_result_t    result,
    output logic                dac_dv,
    output logic                dac_chan,
    output sample_t             dac_data,
    output logic [`N_DDS-1:0]   dds_dv,
    output sample_t             dds_data
);

    logic to_dac;

    assign to_dac = result.chan < chan_t'(`N_DAC);

    // ------------------------------
    // Output strobes
    // ------------------------------
    always_ff @(posedge wr_en) begin
        if (reset) begin
            dac_dv <= 1'b0;
            dds_dv <= '0;
        end else begin
            dac_dv <= result.valid && to_dac;
            // DDS k sits on PID channel N_DAC + k
            for (int k = 0; k < `N_DDS; k++) begin
                dds_dv[k] <= result.valid && (result.chan == chan_t'(`N_DAC + k));
            end
        end
    end

    // Output data
    always_ff @(posedge wr_en) begin
        if (result.valid) begin
            dac_chan <= result.chan[0];
            // Offset binary for the DAC
            dac_data <= {~result.data[`W_SAMPLE-1], result.data[`W_SAMPLE-2:0]};
            dds_data <= result.data;
        end
    end

endmodule

`default_nettype wire

//--- pid/pid_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "pid_defs.svh"

module pid_execute import pid_pkg::*; (
    input  wire logic                           wr_en,
    input  wire logic                           reset,
    input  wire sample_in_t                     sample,
    input  wire pid_gains_t [`N_PID_CHAN-1:0]   gains,
    input  wire logic                           clear,
    input  wire chan_t                          clear_chan,
    output pid_result_t                         result
);

    localparam acc_t SAT_MAX = acc_t'((1 <<< (`W_SAMPLE - 1)) - 1);
    localparam acc_t SAT_MIN = -SAT_MAX - acc_t'(1);

    // Per-channel state
    acc_t integ_q [`N_PID_CHAN];
    acc_t prev_err_q [`N_PID_CHAN];

    // Stage 1 combinational terms
    logic clr_hit;
    acc_t integ_base, prev_base, err, integ_new, diff;

    // Pipeline registers
    logic s1_valid, s2_valid, res_valid;
    chan_t s1_chan, s2_chan, res_chan;
    acc_t s1_err, s1_diff, s1_integ;
    gain_t s1_kp, s1_ki, s1_kd;
    acc_t s2_p, s2_i, s2_d;
    acc_t sum, shifted;
    sample_t sat_data, res_data;

    // ------------------------------
    // Stage 1: error and state update
    // ------------------------------
    // A clear on the same cycle wins over the stored state
    assign clr_hit = clear && (clear_chan == sample.chan);
    assign integ_base = clr_hit ? '0 : integ_q[sample.chan];
    assign prev_base = clr_hit ? '0 : prev_err_q[sample.chan];
    assign err = acc_t'(gains[sample.chan].setpoint) - acc_t'(sample.data);
    assign integ_new = integ_base + err;
    assign diff = err - prev_base;

    always_ff @(posedge wr_en) begin
        if (reset) begin
            for (int c = 0; c < `N_PID_CHAN; c++) begin
                integ_q[c] <= '0;
                prev_err_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < `N_PID_CHAN; c++) begin
                if (clear && (clear_chan == chan_t'(c))) begin
                    integ_q[c] <= '0;
                    prev_err_q[c] <= '0;
                end
                // Sample update already starts from zero after a clear
                if (sample.valid && (sample.chan == chan_t'(c))) begin
                    integ_q[c] <= integ_new;
                    prev_err_q[c] <= err;
                end
            end
        end
    end

    // Valid strobes through the three stages
    always_ff @(posedge wr_en) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid <= sample.valid;
            s2_valid <= s1_valid;
            res_valid <= s2_valid;
        end
    end

    // ------------------------------
    // Stage 3: sum, shift, saturate
    // ------------------------------
    assign sum = s2_p + s2_i + s2_d;
    assign shifted = sum >>> `PID_SHIFT;
    assign sat_data = (shifted > SAT_MAX) ? sample_t'(SAT_MAX) :
                      (shifted < SAT_MIN) ? sample_t'(SAT_MIN) : sample_t'(shifted);

    always_ff @(posedge wr_en) begin
        // Gains are captured with the sample
        s1_chan <= sample.chan;
        s1_err <= err;
        s1_diff <= diff;
        s1_integ <= integ_new;
        s1_kp <= gains[sample.chan].kp;
        s1_ki <= gains[sample.chan].ki;
        s1_kd <= gains[sample.chan].kd;
        // Stage 2 products
        s2_chan <= s1_chan;
        s2_p <= s1_kp * s1_err;
        s2_i <= s1_ki * s1_integ;
        s2_d <= s1_kd * s1_diff;
        res_chan <= s2_chan;
        res_data <= sat_data;
    end

    assign result = '{valid: res_valid, chan: res_chan, data: res_data};

endmodule

`default_nettype wire

//--- hw/cfg_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "pid_defs.svh"

module cfg_decode import pid_pkg::*; (
    input  wire logic                           wr_en,
    input  wire logic                           reset,
    input  wire cfg_write_t                     cfg,
    output pid_gains_t [`N_PID_CHAN-1:0]        gains,
    output logic                                clear,
    output chan_t                               clear_chan
);

    pid_gains_t [`N_PID_CHAN-1:0] table_q;
    logic clear_q;
    chan_t clear_chan_q;
    logic is_clear;

    // Write to the clear register
    assign is_clear = cfg.wr && (cfg.addr == `ADDR_CLEAR);

    // ------------------------------
    // Gain table
    // ------------------------------
    // New value is visible the cycle after the write
    always_ff @(posedge wr_en) begin
        if (reset) begin
            table_q <= '0;
        end else if (cfg.wr) begin
            case (cfg.addr)
                `ADDR_SETPOINT: begin
                    table_q[cfg.chan].setpoint <= sample_t'(cfg.data);
                end
                `ADDR_KP: begin
                    table_q[cfg.chan].kp <= gain_t'(cfg.data);
                end
                `ADDR_KI: begin
                    table_q[cfg.chan].ki <= gain_t'(cfg.data);
                end
                `ADDR_KD: begin
                    table_q[cfg.chan].kd <= gain_t'(cfg.data);
                end
                default: begin
                    // Clear and unused addresses leave the table alone
                end
            endcase
        end
    end

    // ------------------------------
    // Integrator clear pulse
    // ------------------------------
    always_ff @(posedge wr_en) begin
        if (reset) begin
            clear_q <= 1'b0;
        end else begin
            clear_q <= is_clear;
        end
    end

    // Channel only matters while the pulse is high
    always_ff @(posedge wr_en) begin
        if (is_clear) begin
            clear_chan_q <= cfg.chan;
        end
    end

    assign gains = table_q;
    assign clear = clear_q;
    assign clear_chan = clear_chan_q;

endmodule

`default_nettype wire

//--- common/pid_pkg.sv
`default_nettype none

`include "pid_defs.svh"

package pid_pkg;

    // ------------------------------
    // Scalar types
    // ------------------------------
    // ADC value or setpoint
    typedef logic signed [`W_SAMPLE-1:0] sample_t;
    typedef logic signed [`W_GAIN-1:0] gain_t;
    // Integrator and product sums
    typedef logic signed [`W_ACC-1:0] acc_t;
    typedef logic [$clog2(`N_PID_CHAN)-1:0] chan_t;
    typedef logic [`W_CFG_ADDR-1:0] cfg_addr_t;

    // ------------------------------
    // Stage payloads
    // ------------------------------
    // One row of the per-channel gain table
    typedef struct packed {
        sample_t setpoint;
        gain_t kp;
        gain_t ki;
        gain_t kd;
    } pid_gains_t;

    typedef struct packed {
        logic valid;
        chan_t chan;
        sample_t data;
    } sample_in_t;

    // Saturated PID output
    typedef struct packed {
        logic valid;
        chan_t chan;
        sample_t data;
    } pid_result_t;

    // Host write bus, one-cycle wr strobe
    typedef struct packed {
        logic wr;
        cfg_addr_t addr;
        chan_t chan;
        logic [`W_GAIN-1:0] data;
    } cfg_write_t;

endpackage

`default_nettype wire

//--- common/pid_defs.svh
`ifndef PID_DEFS_SVH
`define PID_DEFS_SVH

// Channel counts
`define N_PID_CHAN 4
// PID channels 0 and 1 feed the DAC
`define N_DAC 2
// PID channels 2 and 3 feed DDS 0 and 1
`define N_DDS 2

// Datapath widths
`define W_SAMPLE 16
`define W_GAIN 16
`define W_ACC 32
`define PID_SHIFT 8

// Configuration register map
`define W_CFG_ADDR 3
`define ADDR_SETPOINT 3'd0
`define ADDR_KP 3'd1
`define ADDR_KI 3'd2
`define ADDR_KD 3'd3
`define ADDR_CLEAR 3'd4

`endif
